// ==== conv_pkg.sv ====
package conv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int acc_count       = 4;                  // accumulators / results
    localparam int acc_index_width = $clog2(acc_count);  // result select width
    localparam int steps_width     = 16;                 // programmed step count
    localparam int axil_addr_width = 5;                  // byte address space

    ////////////////////////////////////////////////////////////////////////////
    // register map, byte offsets
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [axil_addr_width-1:0] reg_ctrl    = 5'h00; // start/mode, status
    localparam logic [axil_addr_width-1:0] reg_steps   = 5'h04;
    localparam logic [axil_addr_width-1:0] reg_weight  = 5'h08;
    localparam logic [axil_addr_width-1:0] reg_pixel   = 5'h0C; // also fires a step
    localparam logic [axil_addr_width-1:0] reg_result0 = 5'h10; // results up to 0x1C

    // reg_ctrl bit positions
    localparam int ctrl_start_bit = 0;  // write
    localparam int ctrl_mode_bit  = 1;  // write and read
    localparam int ctrl_busy_bit  = 0;  // read
    localparam int ctrl_done_bit  = 2;  // read

    ////////////////////////////////////////////////////////////////////////////
    // data word, seen as one 16-bit value or as two 8-bit lanes
    ////////////////////////////////////////////////////////////////////////////

    // mode 0 reads wide, mode 1 reads lane[0] (low byte) and lane[1]
    typedef union packed {
        logic signed [15:0] wide;
        logic [1:0][7:0]    lane;
    } data_word_t;

endpackage

// ==== conv_axil_regs.sv ====
`timescale 1ns/1ps

module conv_axil_regs import conv_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [axil_addr_width-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    input  logic [axil_addr_width-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic                       busy,
    input  logic                       done,
    input  logic [31:0]                result_word,
    output logic                       mode,
    output logic [steps_width-1:0]     steps,
    output data_word_t                 weight_word,
    output data_word_t                 pixel_word,
    output logic                       start_pulse,
    output logic                       pixel_pulse,
    output logic [acc_index_width-1:0] rd_index
);

    logic        wr_fire;       // write handshake this cycle
    logic        rd_fire;       // read handshake this cycle
    logic [31:0] rd_data_next;

    assign wr_fire = awvalid && wvalid && awready;
    assign rd_fire = arvalid && arready;

    assign wready = awready;    // address and data taken together
    assign bresp  = 2'b00;      // always OKAY
    assign rresp  = 2'b00;

    ////////////////////////////////////////////////////////////////////////////
    // write channel and register stores
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            awready     <= 1'b0;
            bvalid      <= 1'b0;
            mode        <= 1'b0;
            steps       <= '0;
            weight_word <= '0;
            pixel_word  <= '0;
            start_pulse <= 1'b0;
            pixel_pulse <= 1'b0;
        end else begin
            awready     <= awvalid && wvalid && !bvalid && !awready; // one cycle
            start_pulse <= 1'b0;
            pixel_pulse <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                case (awaddr)
                    reg_ctrl: begin
                        mode        <= wdata[ctrl_mode_bit];
                        start_pulse <= wdata[ctrl_start_bit];
                    end
                    reg_steps:  steps       <= wdata[steps_width-1:0];
                    reg_weight: weight_word <= wdata[15:0];
                    reg_pixel: begin
                        pixel_word  <= wdata[15:0];
                        pixel_pulse <= 1'b1;  // step request to control
                    end
                    default: ;                // unmapped, dropped
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////////////////////

    assign rd_index = araddr[2 +: acc_index_width];  // result number of this read

    always_comb begin
        rd_data_next = '0;
        if (araddr == reg_ctrl) begin
            rd_data_next[ctrl_busy_bit] = busy;
            rd_data_next[ctrl_mode_bit] = mode;
            rd_data_next[ctrl_done_bit] = done;
        end else if (araddr >= reg_result0 && araddr[1:0] == 2'b00) begin
            rd_data_next = result_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_data_next;   // held until rready
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== conv_step_ctrl.sv ====
`timescale 1ns/1ps

module conv_step_ctrl import conv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [steps_width-1:0] steps,
    input  logic                   start_pulse,
    input  logic                   pixel_pulse,
    output logic                   busy,
    output logic                   done,
    output logic                   acc_clear,
    output logic                   mac_en,
    output logic                   capture
);

    logic [steps_width-1:0] step_count;  // accepted pixels this run
    logic [steps_width-1:0] count_next;
    logic                   accept;      // pixel counted as a step
    logic                   last_step;   // current mac_en is the final one
    logic                   start_ok;
    logic                   finish;

    assign start_ok   = start_pulse && !busy;    // start while busy ignored
    assign count_next = step_count + 1'b1;
    assign accept     = pixel_pulse && busy && (step_count < steps);

    // last mac done, or a zero-step run right after the clear
    assign finish = (mac_en && last_step) || (acc_clear && steps == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            acc_clear  <= 1'b0;
            mac_en     <= 1'b0;
            capture    <= 1'b0;
            last_step  <= 1'b0;
            step_count <= '0;
        end else begin
            acc_clear <= start_ok;
            mac_en    <= accept;
            last_step <= accept && (count_next == steps);
            capture   <= finish;
            if (start_ok) begin
                busy       <= 1'b1;
                done       <= 1'b0;
                step_count <= '0;
            end else begin
                if (finish) begin
                    busy <= 1'b0;
                    done <= 1'b1;   // stays until next start
                end
                if (accept) begin
                    step_count <= count_next;
                end
            end
        end
    end

endmodule

// ==== conv_mac_array.sv ====
`timescale 1ns/1ps

module conv_mac_array import conv_pkg::*; #(
    parameter int acc_width = 32
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                mode,
    input  logic                                acc_clear,
    input  logic                                mac_en,
    input  data_word_t                          weight_word,
    input  data_word_t                          pixel_word,
    output logic [acc_count-1:0][acc_width-1:0] acc_sums
);

    logic signed [23:0]          prod_wide;              // 16b pixel x 8b weight
    logic signed [15:0]          prod_lane [acc_count];  // 8b x 8b per pair
    logic signed [acc_width-1:0] addend    [acc_count];

    ////////////////////////////////////////////////////////////////////////////
    // products, both views of the same words
    ////////////////////////////////////////////////////////////////////////////

    assign prod_wide = pixel_word.wide * $signed(weight_word.lane[0]);

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            for (int w = 0; w < 2; w++) begin
                // accumulator 2*p + w pairs pixel lane p with weight lane w
                prod_lane[2*p + w] = $signed(pixel_word.lane[p]) *
                                     $signed(weight_word.lane[w]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < acc_count; i++) begin
            if (mode) begin
                addend[i] = acc_width'(prod_lane[i]);  // narrow, all four
            end else if (i == 0) begin
                addend[i] = acc_width'(prod_wide);     // wide, acc 0 only
            end else begin
                addend[i] = '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulators
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || acc_clear) begin
            acc_sums <= '0;
        end else if (mac_en) begin
            for (int i = 0; i < acc_count; i++) begin
                acc_sums[i] <= acc_sums[i] + addend[i];
            end
        end
    end

endmodule

// ==== conv_result_bank.sv ====
`timescale 1ns/1ps

module conv_result_bank import conv_pkg::*; #(
    parameter int acc_width = 32
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                capture,
    input  logic [acc_count-1:0][acc_width-1:0] acc_sums,
    input  logic [acc_index_width-1:0]          rd_index,
    output logic [31:0]                         result_word
);

    logic [acc_count-1:0][acc_width-1:0] results;   // last completed run
    logic [acc_width-1:0]                selected;

    // snapshot, so a new run can accumulate while old sums are read
    always_ff @(posedge clk) begin
        if (reset) begin
            results <= '0;
        end else if (capture) begin
            results <= acc_sums;
        end
    end

    assign selected = results[rd_index];

    // sign extend below 32 bits, truncate above
    assign result_word = 32'($signed(selected));

endmodule

// ==== conv_front_top.sv ====
`timescale 1ns/1ps

module conv_front_top import conv_pkg::*; #(
    parameter int acc_width = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [axil_addr_width-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    input  logic [axil_addr_width-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    ////////////////////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////////////////////

    logic                                mode;
    logic [steps_width-1:0]              steps;
    data_word_t                          weight_word;
    data_word_t                          pixel_word;
    logic                                start_pulse;
    logic                                pixel_pulse;
    logic [acc_index_width-1:0]          rd_index;
    logic                                busy;
    logic                                done;
    logic                                acc_clear;
    logic                                mac_en;
    logic                                capture;
    logic [acc_count-1:0][acc_width-1:0] acc_sums;
    logic [31:0]                         result_word;

    // decode
    conv_axil_regs u_regs (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .busy(busy), .done(done), .result_word(result_word),
        .mode(mode), .steps(steps),
        .weight_word(weight_word), .pixel_word(pixel_word),
        .start_pulse(start_pulse), .pixel_pulse(pixel_pulse),
        .rd_index(rd_index)
    );

    // execute
    conv_step_ctrl u_step_ctrl (
        .clk(clk), .reset(reset), .steps(steps),
        .start_pulse(start_pulse), .pixel_pulse(pixel_pulse),
        .busy(busy), .done(done),
        .acc_clear(acc_clear), .mac_en(mac_en), .capture(capture)
    );

    conv_mac_array #(.acc_width(acc_width)) u_mac_array (
        .clk(clk), .reset(reset), .mode(mode),
        .acc_clear(acc_clear), .mac_en(mac_en),
        .weight_word(weight_word), .pixel_word(pixel_word),
        .acc_sums(acc_sums)
    );

    // result
    conv_result_bank #(.acc_width(acc_width)) u_result_bank (
        .clk(clk), .reset(reset), .capture(capture),
        .acc_sums(acc_sums), .rd_index(rd_index),
        .result_word(result_word)
    );

endmodule

// ==== tb_axil_tasks.svh ====
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// lcg step, numerical recipes constants
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
        error_count++;
        $display("ERR %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// AXI4-Lite master, called 1 ns after a rising edge
////////////////////////////////////////////////////////////////////////////

task automatic axil_write(input logic [axil_addr_width-1:0] addr, input logic [31:0] data);
    int delay;
    delay   = int'(next_rand() >> 30);  // bready low 0..3 cycles
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!awready) begin
        @(posedge clk);
        #1;
    end
    check_value("wready", 1, wready);  // raised together with awready
    @(posedge clk);                    // handshake edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_value("bvalid", 1, bvalid);
    check_value("bresp", 0, bresp);
    repeat (delay) begin
        @(posedge clk);
        #1;
    end
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
endtask

task automatic axil_read(input logic [axil_addr_width-1:0] addr, output logic [31:0] data,
                         input logic stall);
    int delay;
    delay   = stall ? int'(next_rand() >> 30) : 0;
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
        @(posedge clk);
        #1;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    check_value("rvalid", 1, rvalid);
    check_value("rresp", 0, rresp);
    repeat (delay) begin
        @(posedge clk);
        #1;
    end
    data   = rdata;                    // must still hold after the stall
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
endtask

`endif

// ==== tb_conv_front.sv ====
`timescale 1ns/1ps

module tb_conv_front import conv_pkg::*; ();

    localparam int max_steps      = 32;
    localparam int total_steps    = 12 + 20 + 0 + 10 + 8 + 6;
    localparam int timeout_cycles = total_steps * 40 + 2000;

    typedef logic [15:0] word_list_t [max_steps];
    typedef logic [acc_count-1:0][31:0] sum_set_t;

    logic                       clk;
    logic                       reset;
    logic [axil_addr_width-1:0] awaddr;
    logic [axil_addr_width-1:0] araddr;
    logic [31:0]                wdata;
    logic [31:0]                rdata;
    logic [1:0]                 bresp;
    logic [1:0]                 rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] lcg_state   = 32'h91f1495f;
    word_list_t  pix_list;
    word_list_t  wgt_list;
    sum_set_t    expected;
    sum_set_t    got;
    sum_set_t    got_slow;
    logic [31:0] status;

    `include "tb_axil_tasks.svh"

    conv_front_top #(.acc_width(32)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    // acc 2*p+w sums pixel lane p times weight lane w, wide mode only acc 0
    function automatic sum_set_t conv_ref(input logic m, input word_list_t pix,
                                          input word_list_t wgt, input int n);
        int       sums [acc_count];
        sum_set_t result;
        sums = '{default: 0};
        for (int k = 0; k < n; k++) begin
            if (!m) begin
                sums[0] += int'($signed(pix[k])) * int'($signed(wgt[k][7:0]));
            end else begin
                for (int p = 0; p < 2; p++) begin
                    for (int w = 0; w < 2; w++) begin
                        sums[2*p + w] += int'($signed(pix[k][8*p +: 8])) *
                                         int'($signed(wgt[k][8*w +: 8]));
                    end
                end
            end
        end
        for (int i = 0; i < acc_count; i++) begin
            result[i] = sums[i];
        end
        return result;
    endfunction

    task automatic start_run(input logic m, input int n);
        axil_write(reg_steps, 32'(n));
        axil_write(reg_ctrl, {30'd0, m, 1'b1});
    endtask

    task automatic feed_steps(input int first, input int count);
        for (int k = first; k < first + count; k++) begin
            wgt_list[k] = 16'(next_rand() >> 16);
            pix_list[k] = 16'(next_rand() >> 16);
            axil_write(reg_weight, {16'd0, wgt_list[k]});
            axil_write(reg_pixel, {16'd0, pix_list[k]});  // fires one step
        end
    endtask

    task automatic wait_done();
        do begin
            axil_read(reg_ctrl, status, 1'b0);
        end while (!status[ctrl_done_bit]);
    endtask

    task automatic read_results(output sum_set_t sums, input logic stall);
        logic [31:0] word;
        for (int i = 0; i < acc_count; i++) begin
            axil_read(axil_addr_width'(reg_result0 + 4*i), word, stall);
            sums[i] = word;
        end
    endtask

    task automatic compare_results(input sum_set_t exp, input sum_set_t act);
        for (int i = 0; i < acc_count; i++) begin
            check_value($sformatf("result%0d", i), exp[i], act[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        axil_read(reg_ctrl, status, 1'b0);       // busy, mode, done all low
        check_value("ctrl", 0, status);
        read_results(got, 1'b0);
        compare_results('0, got);

        start_run(1'b0, 12);                     // wide
        feed_steps(0, 12);
        wait_done();
        read_results(got, 1'b0);
        compare_results(conv_ref(1'b0, pix_list, wgt_list, 12), got);

        start_run(1'b1, 20);                     // narrow
        feed_steps(0, 20);
        wait_done();
        read_results(got, 1'b1);
        compare_results(conv_ref(1'b1, pix_list, wgt_list, 20), got);

        start_run(1'b1, 0);                      // zero steps, then idle pixels
        wait_done();
        axil_write(reg_steps, 32'd3);            // count open, but not busy
        feed_steps(0, 3);
        read_results(got, 1'b0);
        compare_results('0, got);

        start_run(1'b1, 10);
        feed_steps(0, 5);
        axil_write(reg_ctrl, 32'h3);             // restart mid run, dropped
        feed_steps(5, 5);
        wait_done();
        expected = conv_ref(1'b1, pix_list, wgt_list, 10);
        read_results(got, 1'b0);
        read_results(got_slow, 1'b1);
        compare_results(expected, got);
        compare_results(expected, got_slow);

        start_run(1'b0, 8);                      // first run results must hold
        feed_steps(0, 8);
        wait_done();
        expected = conv_ref(1'b0, pix_list, wgt_list, 8);
        start_run(1'b1, 6);
        feed_steps(0, 3);
        axil_read(reg_ctrl, status, 1'b0);
        check_value("busy", 1, status[ctrl_busy_bit]);
        read_results(got, 1'b1);
        compare_results(expected, got);
        feed_steps(3, 3);
        wait_done();
        read_results(got, 1'b0);
        compare_results(conv_ref(1'b1, pix_list, wgt_list, 6), got);

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
conv_pkg.sv
conv_axil_regs.sv
conv_step_ctrl.sv
conv_mac_array.sv
conv_result_bank.sv
conv_front_top.sv
tb_conv_front.sv

// ==== Bender.yml ====
package:
  name: conv_front

sources:
  - conv_pkg.sv
  - conv_axil_regs.sv
  - conv_step_ctrl.sv
  - conv_mac_array.sv
  - conv_result_bank.sv
  - conv_front_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_conv_front.sv
